//--- all.f
+incdir+.
isa_pkg.sv
fetch_pkg.sv
fetch_group_if.sv
branch_handler.sv
fetch_unit.sv
fetch_queue.sv
group_issue.sv
fetch_top.sv
fetch_checker.sv
tb_fetch_top.sv

//--- Bender.yml
package:
  name: fetch_front_end

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - isa_pkg.sv
      - fetch_pkg.sv
      - fetch_group_if.sv
      - branch_handler.sv
      - fetch_unit.sv
      - fetch_queue.sv
      - group_issue.sv
      - fetch_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - fetch_checker.sv
      - tb_fetch_top.sv

//--- tb_fetch_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_config.svh"

module tb_fetch_top;

   localparam int PW           = `PC_WIDTH;
   localparam int DW           = `FETCH_WIDTH * 16;
   localparam int NUM_TESTS    = 6;
   localparam int CYC_PER_ITEM = 40;

   logic          clk;
   logic          rst_n;
   logic          wb_cyc;
   logic          wb_stb;
   logic [PW-1:0] wb_adr;
   logic [DW-1:0] wb_dat_i;
   logic          wb_ack;
   logic          issue_valid;
   logic          issue_ready;
   logic [15:0]   issue_inst;
   logic [PW-1:0] issue_pc;
   logic          branch_retire;
   logic          retire_mispredict;
   logic [PW-1:0] retire_pc;
   logic          jump_resolve_valid;
   logic [PW-1:0] jump_resolve_pc;
   logic          branch_hold;

   // instruction memory, one 16-bit word per address
   logic [15:0] mem [65536];

   // per-test knobs
   string test_name;
   int    item_target;
   int    w_plain;
   int    w_back;
   int    w_fwd;
   int    w_jimm;
   int    retire_max;
   int    mis_pct;
   int    ready_pct;
   int    stall_pm;

   // reference model of the issue stream
   logic [PW-1:0] exp_pc;
   bit            pending_jump;
   int            br_in_flight;
   int            items;
   bit            hold_seen;
   bit            prev_hold;
   bit            prev_cyc;

   // memory and back-end timers
   bit ack_busy;
   int ack_wait;
   int retire_wait;
   int jump_wait;
   int stall_left;

   int errors;
   int cycles;
   int cycle_limit;

   fetch_top i_dut (
      .clk                (clk),
      .rst_n              (rst_n),
      .wb_cyc             (wb_cyc),
      .wb_stb             (wb_stb),
      .wb_adr             (wb_adr),
      .wb_dat_i           (wb_dat_i),
      .wb_ack             (wb_ack),
      .issue_valid        (issue_valid),
      .issue_ready        (issue_ready),
      .issue_inst         (issue_inst),
      .issue_pc           (issue_pc),
      .branch_retire      (branch_retire),
      .retire_mispredict  (retire_mispredict),
      .retire_pc          (retire_pc),
      .jump_resolve_valid (jump_resolve_valid),
      .jump_resolve_pc    (jump_resolve_pc),
      .branch_hold        (branch_hold)
   );

   always #5 clk = ~clk;

   //////////////////////////////////////////////////
   // instruction encodings and model rules
   //////////////////////////////////////////////////

   // 0 plain, 1 backward branch, 2 forward branch, 3 imm jump, 4 reg jump
   function automatic logic [15:0] make_word(input int kind);
      logic [15:0] r;
      logic [1:0]  cond;
      r    = 16'($urandom);
      cond = 2'($urandom_range(1, 3));
      case (kind)
         1: make_word = {2'b10, cond, r[11:8], 1'b1, r[6:0]};
         2: make_word = {2'b10, cond, r[11:8], 1'b0, r[6:0]};
         3: make_word = {4'hf, r[11:2], 2'b00};
         4: make_word = {4'hf, r[11:2], 2'($urandom_range(1, 3))};
         // top bit clear, neither jump nor branch
         default: make_word = {1'b0, r[14:0]};
      endcase
   endfunction

   function automatic int pick_kind();
      int p;
      p = $urandom_range(0, 99);
      if (p < w_plain) return 0;
      if (p < w_plain + w_back) return 1;
      if (p < w_plain + w_back + w_fwd) return 2;
      if (p < w_plain + w_back + w_fwd + w_jimm) return 3;
      return 4;
   endfunction

   // class 10, condition nonzero
   function automatic bit is_cond_branch(input logic [15:0] w);
      return w[15:14] == 2'b10 && w[13:12] != 2'b00;
   endfunction

   function automatic bit is_reg_jump(input logic [15:0] w);
      return w[15:12] == 4'hf && w[1:0] != 2'b00;
   endfunction

   // program order successor, register jumps handled by the caller
   function automatic logic [PW-1:0] successor(input logic [PW-1:0] pc,
                                               input logic [15:0] w);
      if (w[15:12] == 4'hf && w[1:0] == 2'b00) begin
         return {pc[PW-1:10], w[11:2]};
      end
      // backward means predicted taken
      if (is_cond_branch(w) && w[7]) begin
         return pc + {{(PW - 8){w[7]}}, w[7:0]};
      end
      return pc + 1'b1;
   endfunction

   // slot 0 in the low word, addresses wrap
   function automatic logic [DW-1:0] read_group(input logic [PW-1:0] adr);
      logic [DW-1:0] d;
      logic [PW-1:0] a;
      for (int i = 0; i < `FETCH_WIDTH; i++) begin
         a             = adr + PW'(i);
         d[i*16 +: 16] = mem[a];
      end
      return d;
   endfunction

   function automatic int test_items(input int t);
      case (t)
         0: return 200;
         1: return 300;
         2: return 200;
         3: return 200;
         4: return 300;
         default: return 300;
      endcase
   endfunction

   task automatic configure(input int t);
      item_target = test_items(t);
      // defaults, then per-test mix
      retire_max  = 4;
      mis_pct     = 0;
      ready_pct   = 90;
      stall_pm    = 0;
      case (t)
         0: begin
            test_name = "straight line";
            w_plain   = 100;
            w_back    = 0;
            w_fwd     = 0;
            w_jimm    = 0;
         end
         1: begin
            test_name = "jumps and taken branches";
            w_plain   = 60;
            w_back    = 15;
            w_fwd     = 5;
            w_jimm    = 20;
            ready_pct = 85;
         end
         2: begin
            test_name  = "branch limit";
            w_plain    = 40;
            w_back     = 10;
            w_fwd      = 50;
            w_jimm     = 0;
            retire_max = 30;
         end
         3: begin
            test_name = "register jumps";
            w_plain   = 75;
            w_back    = 0;
            w_fwd     = 5;
            w_jimm    = 0;
         end
         4: begin
            test_name  = "mispredict";
            w_plain    = 55;
            w_back     = 10;
            w_fwd      = 25;
            w_jimm     = 5;
            retire_max = 6;
            mis_pct    = 20;
         end
         default: begin
            test_name  = "back-pressure";
            w_plain    = 60;
            w_back     = 10;
            w_fwd      = 15;
            w_jimm     = 10;
            retire_max = 6;
            ready_pct  = 70;
            stall_pm   = 30;
         end
      endcase
   endtask

   task automatic fill_memory();
      for (int a = 0; a < 65536; a++) begin
         mem[a] = make_word(pick_kind());
      end
   endtask

   task automatic report_failure(input string what);
      errors++;
      $display("ERROR at %0t: %s", $time, what);
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
      errors++;
      $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, expected, actual);
   endtask

   //////////////////////////////////////////////////
   // memory, back end and stream check
   //////////////////////////////////////////////////

   always @(posedge clk) begin : bench
      logic [15:0] w;
      logic        rdy;
      if (!rst_n) begin
         wb_ack             <= 1'b0;
         wb_dat_i           <= '0;
         issue_ready        <= 1'b0;
         branch_retire      <= 1'b0;
         retire_mispredict  <= 1'b0;
         retire_pc          <= '0;
         jump_resolve_valid <= 1'b0;
         jump_resolve_pc    <= '0;
         exp_pc       = '0;
         pending_jump = 1'b0;
         br_in_flight = 0;
         items        = 0;
         hold_seen    = 1'b0;
         prev_hold    = 1'b0;
         prev_cyc     = 1'b0;
         ack_busy     = 1'b0;
         ack_wait     = 0;
         retire_wait  = 0;
         jump_wait    = 0;
         stall_left   = 0;
         if (wb_cyc || issue_valid || branch_hold) begin
            report_failure("outputs active during reset");
         end
      end else begin
         // held fetch starts no bus cycle
         if (prev_hold && !prev_cyc && wb_cyc) begin
            report_failure("bus cycle started while branch_hold was high");
         end
         if (branch_hold) begin
            hold_seen = 1'b1;
         end
         prev_hold = branch_hold;
         prev_cyc  = wb_cyc;

         // accepted item against the model
         if (issue_valid && issue_ready) begin
            if (pending_jump) begin
               report_failure("instruction issued before the register jump resolved");
            end
            w = mem[exp_pc];
            if (issue_pc !== exp_pc) begin
               report_mismatch("issue_pc", 32'(exp_pc), 32'(issue_pc));
            end
            if (issue_inst !== w) begin
               report_mismatch("issue_inst", 32'(w), 32'(issue_inst));
            end
            items++;
            if (is_cond_branch(w)) begin
               br_in_flight++;
               if (br_in_flight > `MAX_BRANCHES) begin
                  report_failure("more branches issued than the limit allows");
               end
            end
            if (is_reg_jump(w)) begin
               pending_jump = 1'b1;
               jump_wait    = $urandom_range(0, 8);
            end else begin
               exp_pc = successor(exp_pc, w);
            end
         end

         // back-end events applied at this edge
         if (branch_retire && retire_mispredict) begin
            exp_pc       = retire_pc;
            br_in_flight = 0;
            pending_jump = 1'b0;
         end else if (branch_retire) begin
            br_in_flight--;
         end
         if (jump_resolve_valid) begin
            exp_pc       = jump_resolve_pc;
            pending_jump = 1'b0;
         end

         // memory, ack after 0 to 3 wait cycles
         if (wb_ack) begin
            wb_ack   <= 1'b0;
            ack_busy = 1'b0;
         end else if (wb_cyc) begin
            if (!ack_busy) begin
               ack_busy = 1'b1;
               ack_wait = $urandom_range(0, 3);
            end
            if (ack_wait == 0) begin
               wb_ack   <= 1'b1;
               wb_dat_i <= read_group(wb_adr);
            end else begin
               ack_wait--;
            end
         end

         // ready, with occasional long stalls
         if (stall_left > 0) begin
            stall_left--;
            rdy = 1'b0;
         end else if ($urandom_range(0, 999) < stall_pm) begin
            stall_left = $urandom_range(40, 80);
            rdy        = 1'b0;
         end else begin
            rdy = $urandom_range(0, 99) < ready_pct;
         end

         // register jump target after a random delay
         jump_resolve_valid <= 1'b0;
         if (pending_jump && !jump_resolve_valid) begin
            if (jump_wait > 0) begin
               jump_wait--;
            end else begin
               jump_resolve_valid <= 1'b1;
               jump_resolve_pc    <= PW'($urandom);
            end
         end

         // retire oldest issued branch, one pulse at a time
         branch_retire     <= 1'b0;
         retire_mispredict <= 1'b0;
         if (branch_retire) begin
            retire_wait = $urandom_range(0, retire_max);
         end else if (br_in_flight > 0) begin
            if (retire_wait > 0) begin
               retire_wait--;
            end else begin
               branch_retire <= 1'b1;
               if (!pending_jump && $urandom_range(0, 99) < mis_pct) begin
                  retire_mispredict <= 1'b1;
                  retire_pc         <= PW'($urandom);
                  // no handshake on the flush edge
                  rdy = 1'b0;
               end
            end
         end
         issue_ready <= rdy;
      end
   end

   // run limit
   always @(posedge clk) begin
      cycles++;
      if (cycles > cycle_limit) begin
         $display("timeout: run exceeded %0d cycles", cycle_limit);
         $display("Checks failed");
         $finish;
      end
   end

   //////////////////////////////////////////////////
   // test sequence
   //////////////////////////////////////////////////

   initial begin : run_all
      int start_errs;
      int test_errs;
      int total_items;
      int total_errs;
      clk                = 1'b0;
      rst_n              = 1'b0;
      wb_dat_i           = '0;
      wb_ack             = 1'b0;
      issue_ready        = 1'b0;
      branch_retire      = 1'b0;
      retire_mispredict  = 1'b0;
      retire_pc          = '0;
      jump_resolve_valid = 1'b0;
      jump_resolve_pc    = '0;
      errors             = 0;
      cycles             = 0;
      total_items        = 0;
      void'($urandom(32'h884baa3b));
      cycle_limit        = 0;
      for (int t = 0; t < NUM_TESTS; t++) begin
         cycle_limit += test_items(t) * CYC_PER_ITEM;
      end

      for (int t = 0; t < NUM_TESTS; t++) begin
         start_errs = errors + i_dut.i_checker.fail_total;
         @(posedge clk);
         rst_n <= 1'b0;
         // memory changes only while the DUT is in reset
         @(negedge clk);
         configure(t);
         fill_memory();
         repeat (4) @(posedge clk);
         rst_n <= 1'b1;
         while (items < item_target) begin
            @(negedge clk);
         end
         if (t == 2 && !hold_seen) begin
            report_failure("branch_hold never rose in the branch limit test");
         end
         total_items += items;
         test_errs = errors + i_dut.i_checker.fail_total - start_errs;
         $display("test %0d %s: %0d items, %0d errors", t + 1, test_name, items, test_errs);
      end

      total_errs = errors + i_dut.i_checker.fail_total;
      $display("tests %0d, items %0d, errors %0d", NUM_TESTS, total_items, total_errs);
      if (total_errs == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- fetch_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_config.svh"

module fetch_checker (
   input logic                 clk,
   input logic                 rst_n,
   input logic                 wb_cyc,
   input logic                 wb_stb,
   input logic                 wb_ack,
   input logic [`PC_WIDTH-1:0] wb_adr,
   input logic                 issue_valid,
   input logic                 issue_ready,
   input logic [15:0]          issue_inst,
   input logic [`PC_WIDTH-1:0] issue_pc,
   input logic                 branch_retire,
   input logic                 retire_mispredict
);

   // failures per rule
   int adr_fails   = 0;
   int stb_fails   = 0;
   int hold_fails  = 0;
   int reset_fails = 0;
   int fail_total;

   assign fail_total = adr_fails + stb_fails + hold_fails + reset_fails;

   //////////////////////////////////////////////////
   // wishbone
   //////////////////////////////////////////////////

   // address frozen from cyc until the ack edge
   adr_stable_a : assert property (@(posedge clk) disable iff (!rst_n)
      wb_cyc && !wb_ack |=> $stable(wb_adr))
      else begin
         $error("wb_adr changed inside a bus cycle");
         adr_fails++;
      end

   stb_cyc_a : assert property (@(posedge clk) wb_stb == wb_cyc)
      else begin
         $error("wb_stb differs from wb_cyc");
         stb_fails++;
      end

   reset_idle_a : assert property (@(posedge clk) !rst_n |-> !wb_cyc)
      else begin
         $error("wb_cyc high during reset");
         reset_fails++;
      end

   //////////////////////////////////////////////////
   // issue stream
   //////////////////////////////////////////////////

   // a mispredict flush may drop the pending item
   issue_hold_a : assert property (@(posedge clk) disable iff (!rst_n)
      issue_valid && !issue_ready && !(branch_retire && retire_mispredict)
      |=> issue_valid && $stable(issue_inst) && $stable(issue_pc))
      else begin
         $error("issue item changed while waiting for ready");
         hold_fails++;
      end

endmodule

bind fetch_top fetch_checker i_checker (
   .clk               (clk),
   .rst_n             (rst_n),
   .wb_cyc            (wb_cyc),
   .wb_stb            (wb_stb),
   .wb_ack            (wb_ack),
   .wb_adr            (wb_adr),
   .issue_valid       (issue_valid),
   .issue_ready       (issue_ready),
   .issue_inst        (issue_inst),
   .issue_pc          (issue_pc),
   .branch_retire     (branch_retire),
   .retire_mispredict (retire_mispredict)
);

`default_nettype wire

//--- fetch_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_config.svh"

module fetch_top (
   input  logic                       clk,
   input  logic                       rst_n,
   // wishbone classic, read only
   output logic                       wb_cyc,
   output logic                       wb_stb,
   output logic [`PC_WIDTH-1:0]       wb_adr,
   input  logic [`FETCH_WIDTH*16-1:0] wb_dat_i,
   input  logic                       wb_ack,
   // issue stream
   output logic                       issue_valid,
   input  logic                       issue_ready,
   output logic [15:0]                issue_inst,
   output logic [`PC_WIDTH-1:0]       issue_pc,
   // back end
   input  logic                       branch_retire,
   input  logic                       retire_mispredict,
   input  logic [`PC_WIDTH-1:0]       retire_pc,
   input  logic                       jump_resolve_valid,
   input  logic [`PC_WIDTH-1:0]       jump_resolve_pc,
   output logic                       branch_hold
);

   // wrong path, drop everything buffered
   logic flush;

   fetch_group_if q_in ();
   fetch_group_if q_out ();

   assign flush = branch_retire && retire_mispredict;

   fetch_unit i_fetch_unit (
      .clk                (clk),
      .rst_n              (rst_n),
      .wb_cyc             (wb_cyc),
      .wb_stb             (wb_stb),
      .wb_adr             (wb_adr),
      .wb_dat_i           (wb_dat_i),
      .wb_ack             (wb_ack),
      .jump_resolve_valid (jump_resolve_valid),
      .jump_resolve_pc    (jump_resolve_pc),
      .retire             (branch_retire),
      .mispredict         (retire_mispredict),
      .retire_pc          (retire_pc),
      .hold               (branch_hold),
      .grp                (q_in)
   );

   fetch_queue #(
      .DEPTH (`QUEUE_DEPTH)
   ) i_fetch_queue (
      .clk     (clk),
      .rst_n   (rst_n),
      .flush   (flush),
      .in_grp  (q_in),
      .out_grp (q_out)
   );

   group_issue i_group_issue (
      .clk         (clk),
      .rst_n       (rst_n),
      .flush       (flush),
      .grp         (q_out),
      .issue_valid (issue_valid),
      .issue_ready (issue_ready),
      .issue_inst  (issue_inst),
      .issue_pc    (issue_pc)
   );

endmodule

`default_nettype wire

//--- group_issue.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_config.svh"

module group_issue (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 flush,
   fetch_group_if.dst           grp,
   output logic                 issue_valid,
   input  logic                 issue_ready,
   output logic [15:0]          issue_inst,
   output logic [`PC_WIDTH-1:0] issue_pc
);

   localparam int FW = `FETCH_WIDTH;
   localparam int PW = `PC_WIDTH;
   localparam int SW = $clog2(FW);

   fetch_pkg::fetch_group_t cur;
   // slots still to issue
   fetch_pkg::slot_mask_t   rem;
   logic [SW-1:0]           sel;
   logic                    load;

   // idle once every kept slot has gone out
   assign grp.ready   = rem == '0;
   assign load        = grp.valid && grp.ready;
   assign issue_valid = rem != '0;

   // lowest remaining slot, nops are never in rem
   always_comb begin
      sel = '0;
      for (int i = FW - 1; i >= 0; i--) begin
         if (rem[i]) begin
            sel = SW'(i);
         end
      end
   end

   assign issue_inst = cur.words[sel];
   assign issue_pc   = cur.pc + PW'(sel);

   always_ff @(posedge clk) begin
      if (load) begin
         cur <= grp.data;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rem <= '0;
      end else if (flush) begin
         rem <= '0;
      end else if (load) begin
         rem <= grp.data.keep;
      end else if (issue_valid && issue_ready) begin
         rem[sel] <= 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- fetch_queue.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_config.svh"

module fetch_queue #(
   parameter int DEPTH = `QUEUE_DEPTH
) (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       flush,
   fetch_group_if.dst in_grp,
   fetch_group_if.src out_grp
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   fetch_pkg::fetch_group_t mem [DEPTH];
   logic [AW-1:0]           wr_ptr;
   logic [AW-1:0]           rd_ptr;
   logic [CW-1:0]           count;
   logic                    push;
   logic                    pop;

   // wrap for any depth
   function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
      return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign in_grp.ready  = count != CW'(DEPTH);
   assign out_grp.valid = count != '0;
   assign out_grp.data  = mem[rd_ptr];
   assign push          = in_grp.valid && in_grp.ready;
   assign pop           = out_grp.valid && out_grp.ready;

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= in_grp.data;
      end
   end

   // pointers and fill level
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (flush) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         count <= count + CW'(push) - CW'(pop);
      end
   end

endmodule

`default_nettype wire

//--- fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_config.svh"

module fetch_unit (
   input  logic                       clk,
   input  logic                       rst_n,
   output logic                       wb_cyc,
   output logic                       wb_stb,
   output logic [`PC_WIDTH-1:0]       wb_adr,
   input  logic [`FETCH_WIDTH*16-1:0] wb_dat_i,
   input  logic                       wb_ack,
   input  logic                       jump_resolve_valid,
   input  logic [`PC_WIDTH-1:0]       jump_resolve_pc,
   input  logic                       retire,
   input  logic                       mispredict,
   input  logic [`PC_WIDTH-1:0]       retire_pc,
   output logic                       hold,
   fetch_group_if.src                 grp
);

   typedef enum logic [1:0] {S_IDLE, S_BUS, S_JUMP, S_HELD} state_t;

   state_t                            state;
   logic [`PC_WIDTH-1:0]              pc;
   // data of the current bus cycle is from the wrong path
   logic                              drop;
   logic                              redirect;
   logic                              push;
   isa_pkg::inst_u [`FETCH_WIDTH-1:0] words;
   fetch_pkg::slot_mask_t             keep_mask;
   logic [`PC_WIDTH-1:0]              next_pc;
   logic                              wait_jump;

   assign redirect = retire && mispredict;
   // slot 0 in the low word
   assign words    = wb_dat_i;
   assign wb_stb   = wb_cyc;

   // queue entry reserved before cyc, so the push lands on the ack edge
   assign grp.valid = state == S_BUS && wb_ack && !drop && !redirect;
   assign grp.data  = '{pc: wb_adr, words: words, keep: keep_mask};
   assign push      = grp.valid && grp.ready;

   branch_handler i_branch_handler (
      .clk          (clk),
      .rst_n        (rst_n),
      .group_pc     (wb_adr),
      .group_words  (words),
      .group_accept (push),
      .retire       (retire),
      .mispredict   (mispredict),
      .keep_mask    (keep_mask),
      .next_pc      (next_pc),
      .wait_jump    (wait_jump),
      .hold         (hold)
   );

   //////////////////////////////////////////////////
   // request FSM and pc
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state  <= S_IDLE;
         pc     <= '0;
         wb_cyc <= 1'b0;
         wb_adr <= '0;
         drop   <= 1'b0;
      end else begin
         case (state)
            S_IDLE: begin
               if (redirect) begin
                  pc <= retire_pc;
               end else if (hold) begin
                  state <= S_HELD;
               end else if (grp.ready) begin
                  // address frozen for the whole cycle
                  state  <= S_BUS;
                  wb_cyc <= 1'b1;
                  wb_adr <= pc;
               end
            end
            S_BUS: begin
               if (wb_ack) begin
                  wb_cyc <= 1'b0;
                  drop   <= 1'b0;
                  state  <= S_IDLE;
                  if (redirect) begin
                     pc <= retire_pc;
                  end else if (!drop) begin
                     pc <= next_pc;
                     if (wait_jump) begin
                        state <= S_JUMP;
                     end
                  end
               end else if (redirect) begin
                  // stale data still in flight, discard at ack
                  drop <= 1'b1;
                  pc   <= retire_pc;
               end
            end
            S_JUMP: begin
               if (redirect) begin
                  pc    <= retire_pc;
                  state <= S_IDLE;
               end else if (jump_resolve_valid) begin
                  pc    <= jump_resolve_pc;
                  state <= S_IDLE;
               end
            end
            S_HELD: begin
               // branch limit, wait for a retire
               if (redirect) begin
                  pc    <= retire_pc;
                  state <= S_IDLE;
               end else if (!hold) begin
                  state <= S_IDLE;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- branch_handler.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_config.svh"

module branch_handler (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic [`PC_WIDTH-1:0]              group_pc,
   input  isa_pkg::inst_u [`FETCH_WIDTH-1:0] group_words,
   input  logic                              group_accept,
   input  logic                              retire,
   input  logic                              mispredict,
   output fetch_pkg::slot_mask_t             keep_mask,
   output logic [`PC_WIDTH-1:0]              next_pc,
   output logic                              wait_jump,
   output logic                              hold
);

   localparam int FW    = `FETCH_WIDTH;
   localparam int PW    = `PC_WIDTH;
   localparam int CNT_W = $clog2(`MAX_BRANCHES + 1);

   // branches predicted and not yet retired
   logic [CNT_W-1:0] br_cnt;
   // count after the last surviving slot of this group
   logic [CNT_W-1:0] run_cnt;
   // a branch over the limit was cut
   logic             cut;
   logic [FW-1:0]    is_jump;
   logic [FW-1:0]    is_imm_jump;
   logic [FW-1:0]    is_branch;
   logic [FW-1:0]    is_taken;

   //////////////////////////////////////////////////
   // slot classification
   //////////////////////////////////////////////////

   always_comb begin
      for (int i = 0; i < FW; i++) begin
         is_jump[i]     = group_words[i].jmp.opcode == isa_pkg::OP_JUMP;
         is_imm_jump[i] = is_jump[i] && group_words[i].jmp.mode == isa_pkg::JMODE_IMM;
         is_branch[i]   = group_words[i].br.cls == isa_pkg::BR_CLASS &&
                          group_words[i].br.cond != isa_pkg::BR_COND_NONE;
         // static prediction, backward branches taken
         is_taken[i]    = is_branch[i] && group_words[i].br.offset[7];
      end
   end

   //////////////////////////////////////////////////
   // cascaded nop mask and next pc
   //////////////////////////////////////////////////

   always_comb begin : scan
      logic          alive;
      logic [PW-1:0] slot_pc;
      alive     = 1'b1;
      run_cnt   = br_cnt;
      cut       = 1'b0;
      wait_jump = 1'b0;
      keep_mask = '0;
      // straight line by default
      next_pc   = group_pc + PW'(FW);
      for (int i = 0; i < FW; i++) begin
         slot_pc = group_pc + PW'(i);
         // once a slot redirects, everything after it is a nop
         if (alive) begin
            if (is_branch[i] && run_cnt >= CNT_W'(`MAX_BRANCHES)) begin
               // over the limit, refetch from this branch after a retire
               cut     = 1'b1;
               alive   = 1'b0;
               next_pc = slot_pc;
            end else begin
               keep_mask[i] = 1'b1;
               if (is_branch[i]) begin
                  run_cnt = run_cnt + 1'b1;
               end
               if (is_taken[i]) begin
                  alive   = 1'b0;
                  next_pc = slot_pc + {{(PW - 8){group_words[i].br.offset[7]}},
                                       group_words[i].br.offset};
               end else if (is_imm_jump[i]) begin
                  // target replaces the low bits, page kept
                  alive   = 1'b0;
                  next_pc = {slot_pc[PW-1:10], group_words[i].jmp.target};
               end else if (is_jump[i]) begin
                  // register target comes from the back end
                  alive     = 1'b0;
                  wait_jump = 1'b1;
               end
            end
         end
      end
   end

   //////////////////////////////////////////////////
   // branch count and hold
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         br_cnt <= '0;
         hold   <= 1'b0;
      end else if (retire && mispredict) begin
         // wrong path, nothing younger survives
         br_cnt <= '0;
         hold   <= 1'b0;
      end else if (retire) begin
         // branches of a group accepted this cycle still count
         if (group_accept && run_cnt != '0) begin
            br_cnt <= run_cnt - 1'b1;
         end else if (!group_accept && br_cnt != '0) begin
            br_cnt <= br_cnt - 1'b1;
         end
         hold <= 1'b0;
      end else if (group_accept) begin
         br_cnt <= run_cnt;
         if (cut) begin
            hold <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- fetch_group_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fetch_group_if;

   // transfer on an edge with valid and ready both high
   logic                    valid;
   logic                    ready;
   // held stable by the source until accepted
   fetch_pkg::fetch_group_t data;

   // producer side
   modport src (
      output valid,
      output data,
      input  ready
   );

   // consumer side
   modport dst (
      input  valid,
      input  data,
      output ready
   );

endinterface

`default_nettype wire

//--- fetch_pkg.sv
`default_nettype none
`include "fetch_config.svh"

package fetch_pkg;

   // one bit per slot
   // set while the slot still has to issue
   typedef logic [`FETCH_WIDTH-1:0] slot_mask_t;

   // filtered group as produced by the branch handler
   // words[0] sits at pc, words[i] at pc + i
   typedef struct packed {
      logic [`PC_WIDTH-1:0]              pc;
      isa_pkg::inst_u [`FETCH_WIDTH-1:0] words;
      slot_mask_t                        keep;
   } fetch_group_t;

endpackage

`default_nettype wire

//--- isa_pkg.sv
`default_nettype none

package isa_pkg;

   // jump, top nibble all ones
   localparam logic [3:0] OP_JUMP = 4'b1111;
   // conditional branch class
   localparam logic [1:0] BR_CLASS = 2'b10;
   // condition 00 in the branch class is not a branch
   localparam logic [1:0] BR_COND_NONE = 2'b00;
   // jump mode, target taken from the word itself
   localparam logic [1:0] JMODE_IMM = 2'b00;

   // jump word, low bits select immediate or register target
   typedef struct packed {
      logic [3:0] opcode;
      logic [9:0] target;
      logic [1:0] mode;
   } jump_fmt_t;

   // branch word, word offset relative to the branch pc
   typedef struct packed {
      logic [1:0]        cls;
      logic [1:0]        cond;
      logic [3:0]        rs;
      logic signed [7:0] offset;
   } branch_fmt_t;

   // one word seen through both formats during classification
   typedef union packed {
      jump_fmt_t   jmp;
      branch_fmt_t br;
   } inst_u;

endpackage

`default_nettype wire

//--- fetch_config.svh
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// instruction words per fetch group
`define FETCH_WIDTH 4

// predicted branches allowed in flight
`define MAX_BRANCHES 2

// groups buffered between fetch and issue
`define QUEUE_DEPTH 4

// word address width
`define PC_WIDTH 16

`endif
